//--- hdl/mips_isa_pkg.sv
// Instruction set view of the control unit
// Field widths, opcode and function codes, and the two decodings of a word
package mips_isa_pkg;

    // Field widths of a 32-bit instruction word
    localparam int OPCODE_W = 6;
    localparam int REG_W    = 5;
    localparam int SHAMT_W  = 5;
    localparam int FUNCT_W  = 6;
    localparam int IMM_W    = 16;

    // Opcodes kept by this unit
    typedef enum logic [OPCODE_W-1:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_SLTI  = 6'h0A,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_t;

    // Function codes of the R-type ALU group
    typedef enum logic [FUNCT_W-1:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2A
    } funct_t;

    // Register format, opcode in the top bits
    typedef struct packed {
        logic [OPCODE_W-1:0] opcode;
        logic [REG_W-1:0]    rs;
        logic [REG_W-1:0]    rt;
        logic [REG_W-1:0]    rd;
        logic [SHAMT_W-1:0]  shamt;
        logic [FUNCT_W-1:0]  funct;
    } r_fmt_t;

    // Immediate format, shares opcode, rs and rt with the register format
    typedef struct packed {
        logic [OPCODE_W-1:0] opcode;
        logic [REG_W-1:0]    rs;
        logic [REG_W-1:0]    rt;
        logic [IMM_W-1:0]    imm;
    } i_fmt_t;

    // One instruction word, read either way
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_word_u;

endpackage

//--- hdl/ctrl_pkg.sv
// Control side of the unit
// Sequencer states, datapath selects and the control word
package ctrl_pkg;

    // States of the multicycle sequencer
    typedef enum logic [3:0] {
        IDLE            = 4'd0,
        FETCH           = 4'd1,
        DECODE          = 4'd2,
        EXECUTE         = 4'd3,
        WRITE_BACK      = 4'd4,
        ADDR_CALC       = 4'd5,
        MEM_READ        = 4'd6,
        MEM_WRITE       = 4'd7,
        LOAD_WRITE_BACK = 4'd8,
        BRANCH_TARGET   = 4'd9,
        BRANCH_COMPARE  = 4'd10,
        JUMP            = 4'd11,
        ILLEGAL         = 4'd12
    } ctrl_state_t;

    // Instruction classes, each with its own path after DECODE
    typedef enum logic [2:0] {
        CLS_R_ALU   = 3'd0,
        CLS_I_ALU   = 3'd1,
        CLS_LOAD    = 3'd2,
        CLS_STORE   = 3'd3,
        CLS_BRANCH  = 3'd4,
        CLS_JUMP    = 3'd5,
        CLS_ILLEGAL = 3'd6
    } instr_class_t;

    // ALU operations
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_t;

    // Second ALU operand
    typedef enum logic [1:0] {
        SRCB_REG         = 2'd0,
        SRCB_FOUR        = 2'd1,
        SRCB_IMM         = 2'd2,
        SRCB_IMM_SHIFTED = 2'd3
    } alu_src_b_t;

    // Next program counter source
    typedef enum logic [1:0] {
        PCSRC_ALU_RESULT = 2'd0,
        PCSRC_ALU_OUT    = 2'd1,
        PCSRC_JUMP       = 2'd2
    } pc_src_t;

    // Decoder result, held by the sequencer for the whole instruction
    typedef struct packed {
        instr_class_t instr_class;
        alu_op_t      alu_op;
        logic         branch_ne;
        // Destination is rd rather than rt
        logic         reg_dst_rd;
    } decoded_instr_t;

    // One control word for the datapath
    typedef struct packed {
        logic       pc_write;
        logic       ir_write;
        logic       iord;
        logic       mem_write;
        logic       mem_read;
        logic       reg_write;
        logic       reg_dst_rd;
        logic       mem_to_reg;
        logic       alu_src_a_reg;
        alu_src_b_t alu_src_b;
        alu_op_t    alu_op;
        pc_src_t    pc_src;
        logic       alu_out_latch;
        logic       branch;
        logic       branch_ne;
        logic       illegal;
    } ctrl_word_t;

endpackage

//--- hdl/instr_decoder.sv
`timescale 1ns/1ps

// Stage one of the control unit
module instr_decoder
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      step,
    input  mips_isa_pkg::instr_word_u instr,
    output ctrl_pkg::decoded_instr_t  dec
);

    // Classification of the current word, before the register
    ctrl_pkg::decoded_instr_t dec_d;

    always_comb
    begin
        // Anything not matched below is reported as illegal
        dec_d.instr_class = ctrl_pkg::CLS_ILLEGAL;
        dec_d.alu_op      = ctrl_pkg::ALU_ADD;
        dec_d.branch_ne   = 1'b0;
        dec_d.reg_dst_rd  = 1'b0;

        // Opcode sits in the same bits in both views
        case (instr.i.opcode)
            mips_isa_pkg::OP_RTYPE:
            begin
                // R-type, operation comes from the function field
                case (instr.r.funct)
                    mips_isa_pkg::FN_ADD: dec_d.alu_op = ctrl_pkg::ALU_ADD;
                    mips_isa_pkg::FN_SUB: dec_d.alu_op = ctrl_pkg::ALU_SUB;
                    mips_isa_pkg::FN_AND: dec_d.alu_op = ctrl_pkg::ALU_AND;
                    mips_isa_pkg::FN_OR:  dec_d.alu_op = ctrl_pkg::ALU_OR;
                    mips_isa_pkg::FN_SLT: dec_d.alu_op = ctrl_pkg::ALU_SLT;
                    default:              dec_d.alu_op = ctrl_pkg::ALU_ADD;
                endcase
                case (instr.r.funct)
                    mips_isa_pkg::FN_ADD,
                    mips_isa_pkg::FN_SUB,
                    mips_isa_pkg::FN_AND,
                    mips_isa_pkg::FN_OR,
                    mips_isa_pkg::FN_SLT:
                    begin
                        dec_d.instr_class = ctrl_pkg::CLS_R_ALU;
                        // Only R-type writes to rd
                        dec_d.reg_dst_rd  = 1'b1;
                    end
                    default:
                    begin
                        // Unknown funct stays illegal
                        dec_d.instr_class = ctrl_pkg::CLS_ILLEGAL;
                    end
                endcase
            end
            mips_isa_pkg::OP_ADDI:
            begin
                dec_d.instr_class = ctrl_pkg::CLS_I_ALU;
            end
            mips_isa_pkg::OP_ANDI:
            begin
                dec_d.instr_class = ctrl_pkg::CLS_I_ALU;
                dec_d.alu_op      = ctrl_pkg::ALU_AND;
            end
            mips_isa_pkg::OP_ORI:
            begin
                dec_d.instr_class = ctrl_pkg::CLS_I_ALU;
                dec_d.alu_op      = ctrl_pkg::ALU_OR;
            end
            mips_isa_pkg::OP_SLTI:
            begin
                dec_d.instr_class = ctrl_pkg::CLS_I_ALU;
                dec_d.alu_op      = ctrl_pkg::ALU_SLT;
            end
            // Loads and stores add the offset to the base register
            mips_isa_pkg::OP_LW: dec_d.instr_class = ctrl_pkg::CLS_LOAD;
            mips_isa_pkg::OP_SW: dec_d.instr_class = ctrl_pkg::CLS_STORE;
            mips_isa_pkg::OP_BEQ,
            mips_isa_pkg::OP_BNE:
            begin
                // Both branches compare by subtraction
                dec_d.instr_class = ctrl_pkg::CLS_BRANCH;
                dec_d.alu_op      = ctrl_pkg::ALU_SUB;
                dec_d.branch_ne   = (instr.i.opcode == mips_isa_pkg::OP_BNE);
            end
            mips_isa_pkg::OP_J: dec_d.instr_class = ctrl_pkg::CLS_JUMP;
            default:
            begin
                dec_d.instr_class = ctrl_pkg::CLS_ILLEGAL;
            end
        endcase
    end

    // Result register, advances only on a step
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            dec <= '0;
        end
        else if (step)
        begin
            dec <= dec_d;
        end
    end

endmodule

//--- hdl/control_sequencer.sv
`timescale 1ns/1ps

// Stage two of the control unit
// One state per stepped edge, one instruction at a time
module control_sequencer
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     step,
    input  ctrl_pkg::decoded_instr_t dec,
    output ctrl_pkg::ctrl_state_t    state,
    output ctrl_pkg::decoded_instr_t dec_q
);

    ctrl_pkg::ctrl_state_t state_d;

    // Next state
    always_comb
    begin
        state_d = state;
        case (state)
            ctrl_pkg::IDLE:
            begin
                state_d = ctrl_pkg::FETCH;
            end
            ctrl_pkg::FETCH:
            begin
                state_d = ctrl_pkg::DECODE;
            end
            ctrl_pkg::DECODE:
            begin
                // Branch by class of the freshly decoded word
                case (dec.instr_class)
                    ctrl_pkg::CLS_R_ALU,
                    ctrl_pkg::CLS_I_ALU:  state_d = ctrl_pkg::EXECUTE;
                    ctrl_pkg::CLS_LOAD,
                    ctrl_pkg::CLS_STORE:  state_d = ctrl_pkg::ADDR_CALC;
                    ctrl_pkg::CLS_BRANCH: state_d = ctrl_pkg::BRANCH_TARGET;
                    ctrl_pkg::CLS_JUMP:   state_d = ctrl_pkg::JUMP;
                    default:              state_d = ctrl_pkg::ILLEGAL;
                endcase
            end
            ctrl_pkg::EXECUTE:
            begin
                state_d = ctrl_pkg::WRITE_BACK;
            end
            ctrl_pkg::ADDR_CALC:
            begin
                // Class was captured at DECODE
                if (dec_q.instr_class == ctrl_pkg::CLS_LOAD)
                begin
                    state_d = ctrl_pkg::MEM_READ;
                end
                else
                begin
                    state_d = ctrl_pkg::MEM_WRITE;
                end
            end
            ctrl_pkg::MEM_READ:
            begin
                state_d = ctrl_pkg::LOAD_WRITE_BACK;
            end
            ctrl_pkg::BRANCH_TARGET:
            begin
                state_d = ctrl_pkg::BRANCH_COMPARE;
            end
            // Last state of every path
            ctrl_pkg::WRITE_BACK,
            ctrl_pkg::LOAD_WRITE_BACK,
            ctrl_pkg::MEM_WRITE,
            ctrl_pkg::BRANCH_COMPARE,
            ctrl_pkg::JUMP,
            ctrl_pkg::ILLEGAL:
            begin
                state_d = ctrl_pkg::FETCH;
            end
            default:
            begin
                // Unused encodings recover through IDLE
                state_d = ctrl_pkg::IDLE;
            end
        endcase
    end

    // State register, held while step is low
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            state <= ctrl_pkg::IDLE;
        end
        else if (step)
        begin
            state <= state_d;
        end
    end

    // Decoded instruction kept stable after DECODE while instr moves on
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            dec_q <= '0;
        end
        else if (step && (state == ctrl_pkg::DECODE))
        begin
            dec_q <= dec;
        end
    end

endmodule

//--- hdl/control_word_gen.sv
`timescale 1ns/1ps

// Stage three of the control unit
// Registered control word per state, plus the PC enable
module control_word_gen
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     step,
    input  logic                     zero,
    input  ctrl_pkg::ctrl_state_t    state,
    input  ctrl_pkg::decoded_instr_t dec_q,
    output ctrl_pkg::ctrl_word_t     ctrl,
    output logic                     pc_en
);

    ctrl_pkg::ctrl_word_t word_d;

    always_comb
    begin
        // Fields not set for a state stay low
        word_d = '0;
        case (state)
            ctrl_pkg::FETCH:
            begin
                // Load IR and compute PC + 4
                word_d.ir_write  = 1'b1;
                word_d.pc_write  = 1'b1;
                word_d.alu_src_b = ctrl_pkg::SRCB_FOUR;
                word_d.alu_op    = ctrl_pkg::ALU_ADD;
                word_d.pc_src    = ctrl_pkg::PCSRC_ALU_RESULT;
            end
            ctrl_pkg::DECODE:
            begin
                // Register file read into A
                word_d.alu_src_a_reg = 1'b1;
            end
            ctrl_pkg::EXECUTE:
            begin
                word_d.alu_src_a_reg = 1'b1;
                word_d.alu_out_latch = 1'b1;
                word_d.alu_op        = dec_q.alu_op;
                // R-type takes rt, I-type the immediate
                if (dec_q.instr_class == ctrl_pkg::CLS_R_ALU)
                begin
                    word_d.alu_src_b = ctrl_pkg::SRCB_REG;
                end
                else
                begin
                    word_d.alu_src_b = ctrl_pkg::SRCB_IMM;
                end
            end
            ctrl_pkg::WRITE_BACK:
            begin
                word_d.reg_write  = 1'b1;
                word_d.reg_dst_rd = dec_q.reg_dst_rd;
            end
            ctrl_pkg::ADDR_CALC:
            begin
                // Base plus offset
                word_d.alu_src_a_reg = 1'b1;
                word_d.alu_src_b     = ctrl_pkg::SRCB_IMM;
                word_d.alu_op        = ctrl_pkg::ALU_ADD;
                word_d.alu_out_latch = 1'b1;
            end
            ctrl_pkg::MEM_READ:
            begin
                word_d.iord     = 1'b1;
                word_d.mem_read = 1'b1;
            end
            ctrl_pkg::LOAD_WRITE_BACK:
            begin
                word_d.reg_write  = 1'b1;
                word_d.mem_to_reg = 1'b1;
            end
            ctrl_pkg::MEM_WRITE:
            begin
                word_d.iord      = 1'b1;
                word_d.mem_write = 1'b1;
            end
            ctrl_pkg::BRANCH_TARGET:
            begin
                // PC + 4 plus the word offset, held in ALUOut
                word_d.alu_src_b     = ctrl_pkg::SRCB_IMM_SHIFTED;
                word_d.alu_op        = ctrl_pkg::ALU_ADD;
                word_d.alu_out_latch = 1'b1;
            end
            ctrl_pkg::BRANCH_COMPARE:
            begin
                // rs minus rt, target taken from ALUOut
                word_d.alu_src_a_reg = 1'b1;
                word_d.alu_op        = ctrl_pkg::ALU_SUB;
                word_d.pc_src        = ctrl_pkg::PCSRC_ALU_OUT;
                word_d.branch        = 1'b1;
                word_d.branch_ne     = dec_q.branch_ne;
            end
            ctrl_pkg::JUMP:
            begin
                word_d.pc_write = 1'b1;
                word_d.pc_src   = ctrl_pkg::PCSRC_JUMP;
            end
            ctrl_pkg::ILLEGAL: word_d.illegal = 1'b1;
            default:
            begin
                word_d = '0;
            end
        endcase
    end

    // Word register, held while step is low
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            ctrl <= '0;
        end
        else if (step)
        begin
            ctrl <= word_d;
        end
    end

    // Taken branch when zero differs from branch_ne
    assign pc_en = ctrl.pc_write | (ctrl.branch & (zero ^ ctrl.branch_ne));

endmodule

//--- hdl/control_unit.sv
`timescale 1ns/1ps

// Multicycle control unit
// Decoder, sequencer and word generator in a chain of registered stages
module control_unit
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      step,
    input  mips_isa_pkg::instr_word_u instr,
    input  logic                      zero,
    output ctrl_pkg::ctrl_word_t      ctrl,
    output logic                      pc_en
);

    // Stage one to stage two
    ctrl_pkg::decoded_instr_t dec;
    // Stage two to stage three
    ctrl_pkg::ctrl_state_t    state;
    ctrl_pkg::decoded_instr_t dec_q;

    instr_decoder i_instr_decoder
    (
        .clk   (clk),
        .reset (reset),
        .step  (step),
        .instr (instr),
        .dec   (dec)
    );

    control_sequencer i_control_sequencer
    (
        .clk   (clk),
        .reset (reset),
        .step  (step),
        .dec   (dec),
        .state (state),
        .dec_q (dec_q)
    );

    control_word_gen i_control_word_gen
    (
        .clk   (clk),
        .reset (reset),
        .step  (step),
        .zero  (zero),
        .state (state),
        .dec_q (dec_q),
        .ctrl  (ctrl),
        .pc_en (pc_en)
    );

endmodule

//--- dv/control_unit_tb.sv
`timescale 1ns/1ps

// Testbench for the multicycle control unit
// Reference model runs at the drive point, assertions sample at the falling edge
module control_unit_tb;

    localparam int          NUM_INSTR      = 300;
    // Five steps per instruction at most, four cycles per step at most
    localparam int          TIMEOUT_CYCLES = NUM_INSTR * 5 * 4 + 100;
    localparam int          NUM_KINDS      = 14;
    localparam logic [31:0] SEED           = 32'h8927a28c;

    // Legal kinds in the order add sub and or slt addi andi ori slti lw sw beq bne j
    localparam logic [5:0] KIND_OP [NUM_KINDS] = '{
        6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h08, 6'h0C,
        6'h0D, 6'h0A, 6'h23, 6'h2B, 6'h04, 6'h05, 6'h02
    };
    localparam logic [5:0] KIND_FN [NUM_KINDS] = '{
        6'h20, 6'h22, 6'h24, 6'h25, 6'h2A, 6'h00, 6'h00,
        6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00
    };
    localparam ctrl_pkg::instr_class_t KIND_CLS [NUM_KINDS] = '{
        ctrl_pkg::CLS_R_ALU, ctrl_pkg::CLS_R_ALU, ctrl_pkg::CLS_R_ALU,
        ctrl_pkg::CLS_R_ALU, ctrl_pkg::CLS_R_ALU, ctrl_pkg::CLS_I_ALU,
        ctrl_pkg::CLS_I_ALU, ctrl_pkg::CLS_I_ALU, ctrl_pkg::CLS_I_ALU,
        ctrl_pkg::CLS_LOAD, ctrl_pkg::CLS_STORE, ctrl_pkg::CLS_BRANCH,
        ctrl_pkg::CLS_BRANCH, ctrl_pkg::CLS_JUMP
    };
    localparam ctrl_pkg::alu_op_t KIND_ALU [NUM_KINDS] = '{
        ctrl_pkg::ALU_ADD, ctrl_pkg::ALU_SUB, ctrl_pkg::ALU_AND, ctrl_pkg::ALU_OR,
        ctrl_pkg::ALU_SLT, ctrl_pkg::ALU_ADD, ctrl_pkg::ALU_AND, ctrl_pkg::ALU_OR,
        ctrl_pkg::ALU_SLT, ctrl_pkg::ALU_ADD, ctrl_pkg::ALU_ADD, ctrl_pkg::ALU_SUB,
        ctrl_pkg::ALU_SUB, ctrl_pkg::ALU_ADD
    };
    // Opcodes and R-type funct codes outside the kept set
    localparam logic [5:0] BAD_OP [4] = '{6'h01, 6'h10, 6'h1F, 6'h3F};
    localparam logic [5:0] BAD_FN [4] = '{6'h00, 6'h08, 6'h21, 6'h2B};

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      step;
    mips_isa_pkg::instr_word_u instr;
    logic                      zero;
    ctrl_pkg::ctrl_word_t      ctrl;
    logic                      pc_en;

    // Reference model of the state and of the current instruction
    ctrl_pkg::ctrl_state_t     m_state;
    ctrl_pkg::ctrl_word_t      m_word;
    ctrl_pkg::instr_class_t    cur_cls;
    ctrl_pkg::alu_op_t         cur_alu;
    logic                      cur_bne;

    // Observations of the DUT words
    ctrl_pkg::instr_class_t    shown_cls;
    ctrl_pkg::ctrl_word_t      ctrl_last;
    ctrl_pkg::ctrl_word_t      ctrl_before;
    logic [31:0]               rng;
    logic [1:0]                gap_left;
    int                        cycle_count = 0;
    int                        done_count;
    int                        word_count;
    int                        last_len;
    int                        exp_len;
    logic                      stepped_once;
    logic                      have_prev;
    logic                      len_check;
    logic                      hold_edge;
    logic                      was_illegal;
    logic                      fetch_check;

    control_unit i_control_unit
    (
        .clk   (clk),
        .reset (reset),
        .step  (step),
        .instr (instr),
        .zero  (zero),
        .ctrl  (ctrl),
        .pc_en (pc_en)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Path through the states after each one
    function automatic ctrl_pkg::ctrl_state_t next_state(input ctrl_pkg::ctrl_state_t s,
                                                         input ctrl_pkg::instr_class_t c);
        case (s)
            ctrl_pkg::IDLE:          return ctrl_pkg::FETCH;
            ctrl_pkg::FETCH:         return ctrl_pkg::DECODE;
            ctrl_pkg::DECODE:
            begin
                case (c)
                    ctrl_pkg::CLS_R_ALU, ctrl_pkg::CLS_I_ALU: return ctrl_pkg::EXECUTE;
                    ctrl_pkg::CLS_LOAD, ctrl_pkg::CLS_STORE:  return ctrl_pkg::ADDR_CALC;
                    ctrl_pkg::CLS_BRANCH:                     return ctrl_pkg::BRANCH_TARGET;
                    ctrl_pkg::CLS_JUMP:                       return ctrl_pkg::JUMP;
                    default:                                  return ctrl_pkg::ILLEGAL;
                endcase
            end
            ctrl_pkg::EXECUTE:       return ctrl_pkg::WRITE_BACK;
            ctrl_pkg::ADDR_CALC:
                return (c == ctrl_pkg::CLS_LOAD) ? ctrl_pkg::MEM_READ : ctrl_pkg::MEM_WRITE;
            ctrl_pkg::MEM_READ:      return ctrl_pkg::LOAD_WRITE_BACK;
            ctrl_pkg::BRANCH_TARGET: return ctrl_pkg::BRANCH_COMPARE;
            default:                 return ctrl_pkg::FETCH;
        endcase
    endfunction

    // Expected word for a state, all other fields low
    function automatic ctrl_pkg::ctrl_word_t state_word(input ctrl_pkg::ctrl_state_t s,
                                                        input ctrl_pkg::instr_class_t c,
                                                        input ctrl_pkg::alu_op_t op,
                                                        input logic bne);
        ctrl_pkg::ctrl_word_t w;
        w = '0;
        case (s)
            ctrl_pkg::FETCH:
            begin
                w.ir_write  = 1'b1;
                w.pc_write  = 1'b1;
                w.alu_src_b = ctrl_pkg::SRCB_FOUR;
                w.alu_op    = ctrl_pkg::ALU_ADD;
                w.pc_src    = ctrl_pkg::PCSRC_ALU_RESULT;
            end
            ctrl_pkg::DECODE: w.alu_src_a_reg = 1'b1;
            ctrl_pkg::EXECUTE:
            begin
                w.alu_src_a_reg = 1'b1;
                w.alu_out_latch = 1'b1;
                w.alu_op        = op;
                w.alu_src_b     = (c == ctrl_pkg::CLS_R_ALU) ? ctrl_pkg::SRCB_REG
                                                              : ctrl_pkg::SRCB_IMM;
            end
            ctrl_pkg::WRITE_BACK:
            begin
                w.reg_write  = 1'b1;
                // rd only for R-type
                w.reg_dst_rd = (c == ctrl_pkg::CLS_R_ALU);
            end
            ctrl_pkg::ADDR_CALC:
            begin
                w.alu_src_a_reg = 1'b1;
                w.alu_src_b     = ctrl_pkg::SRCB_IMM;
                w.alu_op        = ctrl_pkg::ALU_ADD;
                w.alu_out_latch = 1'b1;
            end
            ctrl_pkg::MEM_READ:
            begin
                w.iord     = 1'b1;
                w.mem_read = 1'b1;
            end
            ctrl_pkg::LOAD_WRITE_BACK:
            begin
                w.reg_write  = 1'b1;
                w.mem_to_reg = 1'b1;
            end
            ctrl_pkg::MEM_WRITE:
            begin
                w.iord      = 1'b1;
                w.mem_write = 1'b1;
            end
            ctrl_pkg::BRANCH_TARGET:
            begin
                w.alu_src_b     = ctrl_pkg::SRCB_IMM_SHIFTED;
                w.alu_op        = ctrl_pkg::ALU_ADD;
                w.alu_out_latch = 1'b1;
            end
            ctrl_pkg::BRANCH_COMPARE:
            begin
                w.alu_src_a_reg = 1'b1;
                w.alu_op        = ctrl_pkg::ALU_SUB;
                w.pc_src        = ctrl_pkg::PCSRC_ALU_OUT;
                w.branch        = 1'b1;
                w.branch_ne     = bne;
            end
            ctrl_pkg::JUMP:
            begin
                w.pc_write = 1'b1;
                w.pc_src   = ctrl_pkg::PCSRC_JUMP;
            end
            ctrl_pkg::ILLEGAL: w.illegal = 1'b1;
            default: w = '0;
        endcase
        return w;
    endfunction

    // Stepped words from one FETCH word to the next
    function automatic int steps_of_class(input ctrl_pkg::instr_class_t c);
        case (c)
            ctrl_pkg::CLS_LOAD:                        return 5;
            ctrl_pkg::CLS_JUMP, ctrl_pkg::CLS_ILLEGAL: return 3;
            default:                                   return 4;
        endcase
    endfunction

    // beq taken on zero, bne taken on not zero
    function automatic logic expect_pc_en(input ctrl_pkg::ctrl_word_t w, input logic z);
        if (w.branch)
            return w.branch_ne ? !z : z;
        return w.pc_write;
    endfunction

    task automatic end_with_failure(input string reason);
        $display("Simulation FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic report_mismatch(input string test_name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERR %s expected 0x%0h actual 0x%0h", test_name, expected, actual);
        end_with_failure("a check found a wrong value");
    endtask

    // New random word and its expected class, operation and branch sense
    task automatic issue_instr();
        logic [3:0] kind;
        rng   = xorshift32(rng);
        // Register fields and immediate stay random
        instr = rng;
        rng   = xorshift32(rng);
        if (rng[2:0] == 3'd0)
        begin
            // About one in eight undefined
            cur_cls = ctrl_pkg::CLS_ILLEGAL;
            cur_alu = ctrl_pkg::ALU_ADD;
            cur_bne = 1'b0;
            if (rng[3])
                instr.i.opcode = BAD_OP[rng[5:4]];
            else
            begin
                instr.r.opcode = 6'h00;
                instr.r.funct  = BAD_FN[rng[5:4]];
            end
        end
        else
        begin
            kind           = 4'(rng[31:8] % NUM_KINDS);
            instr.i.opcode = KIND_OP[kind];
            if (KIND_OP[kind] == 6'h00)
                instr.r.funct = KIND_FN[kind];
            cur_cls = KIND_CLS[kind];
            cur_alu = KIND_ALU[kind];
            cur_bne = (KIND_OP[kind] == 6'h05);
        end
    endtask

    // One clock cycle, observe and model just after the edge, then drive
    task run_cycle();
        @(posedge clk);
        #2;
        len_check   = 1'b0;
        fetch_check = 1'b0;
        if (step)
        begin
            stepped_once = 1'b1;
            if (ctrl.ir_write)
            begin
                // Close the length count of the previous instruction
                if (have_prev)
                begin
                    len_check  = 1'b1;
                    last_len   = word_count;
                    exp_len    = steps_of_class(shown_cls);
                    done_count = done_count + 1;
                end
                have_prev  = 1'b1;
                shown_cls  = cur_cls;
                word_count = 1;
            end
            else
                word_count = word_count + 1;
            fetch_check = was_illegal;
            was_illegal = ctrl.illegal;
            // Word of the state just left, then the move
            m_word  = state_word(m_state, cur_cls, cur_alu, cur_bne);
            m_state = next_state(m_state, cur_cls);
            if (m_state == ctrl_pkg::FETCH)
                issue_instr();
        end
        hold_edge   = !step;
        ctrl_before = ctrl_last;
        ctrl_last   = ctrl;
        rng  = xorshift32(rng);
        zero = rng[9];
        if (gap_left != 2'd0)
        begin
            step     = 1'b0;
            gap_left = gap_left - 2'd1;
        end
        else
        begin
            step     = 1'b1;
            gap_left = rng[1:0];
        end
    endtask

    // Run limit
    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES)
            end_with_failure("timeout because the run did not finish within the cycle limit");
    end

    // Behavior checks, sampled mid cycle where every signal is settled
    assert property (@(negedge clk) !stepped_once |-> (ctrl == '0 && !pc_en))
        else report_mismatch("reset_idle", 32'd0, 32'({ctrl, pc_en}));
    assert property (@(negedge clk) disable iff (!reset) ctrl == m_word)
        else report_mismatch("ctrl_word", 32'(m_word), 32'(ctrl));
    assert property (@(negedge clk) disable iff (!reset) len_check |-> last_len == exp_len)
        else report_mismatch("seq_length", exp_len, last_len);
    assert property (@(negedge clk) disable iff (!reset) hold_edge |-> ctrl == ctrl_before)
        else report_mismatch("back_pressure", 32'(ctrl_before), 32'(ctrl));
    assert property (@(negedge clk) disable iff (!reset) pc_en == expect_pc_en(m_word, zero))
        else report_mismatch("pc_enable", 32'(expect_pc_en(m_word, zero)), 32'(pc_en));
    assert property (@(negedge clk) disable iff (!reset)
        m_word.illegal |-> (ctrl.illegal && !ctrl.reg_write && !ctrl.mem_write))
        else report_mismatch("illegal_word", 32'(m_word), 32'(ctrl));
    assert property (@(negedge clk) disable iff (!reset) fetch_check |-> ctrl.ir_write)
        else report_mismatch("illegal_then_fetch", 32'd1, 32'(ctrl.ir_write));

    initial
    begin
        reset        = 1'b0;
        step         = 1'b0;
        instr        = '0;
        zero         = 1'b0;
        rng          = SEED;
        gap_left     = 2'd0;
        m_state      = ctrl_pkg::IDLE;
        m_word       = '0;
        cur_cls      = ctrl_pkg::CLS_ILLEGAL;
        cur_alu      = ctrl_pkg::ALU_ADD;
        cur_bne      = 1'b0;
        shown_cls    = ctrl_pkg::CLS_ILLEGAL;
        ctrl_last    = '0;
        ctrl_before  = '0;
        done_count   = 0;
        word_count   = 0;
        last_len     = 0;
        exp_len      = 0;
        stepped_once = 1'b0;
        have_prev    = 1'b0;
        len_check    = 1'b0;
        hold_edge    = 1'b0;
        was_illegal  = 1'b0;
        fetch_check  = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b1;
        while (done_count < NUM_INSTR)
            run_cycle();
        // Freeze the DUT so the last word stays matched to the model
        step = 1'b0;
        @(negedge clk);
        @(negedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- control_unit.f
hdl/mips_isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/instr_decoder.sv
hdl/control_sequencer.sv
hdl/control_word_gen.sv
hdl/control_unit.sv
dv/control_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module control_unit_tb \
    --Mdir obj_dir -o control_unit_sim \
    -f control_unit.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/control_unit_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
    echo "Testbench reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
exit 0
